// ==== source/pan_tilt_pkg.sv ====
/*
 * pan/tilt motion calculator shared definitions
 * widths, angle units, CORDIC table and gain
 */
`default_nettype none

package pan_tilt_pkg;

	////////////////////////////////////////
	// coordinates

	// floor positions and light height
	localparam int POS_W = 12;
	typedef logic [POS_W-1:0] pos_t;

	// CORDIC x/y, wide enough for gain growth through both chains
	localparam int VEC_W = 18;
	typedef logic signed [VEC_W-1:0] vec_t;

	////////////////////////////////////////
	// angles

	// binary angle, 65536 is one full turn
	localparam int ANG_W = 16;
	typedef logic [ANG_W-1:0] ang_t;

	localparam ang_t HALF_TURN    = 16'd32768;
	localparam ang_t QUARTER_TURN = 16'd16384;

	////////////////////////////////////////
	// CORDIC

	// iterations per chain
	localparam int N_STAGES = 14;

	// atan(2^-i) in angle units, rounded
	localparam ang_t ATAN_TABLE [0:N_STAGES-1] = '{
		16'd8192, 16'd4836, 16'd2555, 16'd1297,
		16'd651,  16'd326,  16'd163,  16'd81,
		16'd41,   16'd20,   16'd10,   16'd5,
		16'd3,    16'd1
	};

	// chain gain 1.6468 in Q14
	localparam logic [15:0] CORDIC_GAIN = 16'd26981;
	localparam int GAIN_FRAC = 14;

	////////////////////////////////////////
	// DMX output

	typedef logic [7:0] dmx_t;

	// a quarter turn of tilt lands on 256
	localparam int TILT_SHIFT = 6;

	// setup + two chains + output mapper
	localparam int LATENCY = 30;

endpackage

`default_nettype wire

// ==== source/aim_setup.sv ====
/*
 * aim setup: light-to-target vector, folded into the right half-plane,
 * plus the light height pre-scaled by the CORDIC gain
 */
`timescale 1ns/1ps
`default_nettype none

module aim_setup import pan_tilt_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  pos_t x_com,
	input  pos_t y_com,
	input  pos_t x_light,
	input  pos_t y_light,
	input  pos_t height,
	output logic out_valid,
	output vec_t out_x,
	output vec_t out_y,
	output ang_t out_z,
	output vec_t out_aux
);

	// raw differences need one extra bit for the sign
	logic signed [POS_W:0] dx;
	logic signed [POS_W:0] dy;

	// folded vector and its starting angle
	vec_t fold_x;
	vec_t fold_y;
	ang_t fold_z;

	// height times gain, full product before the shift
	logic [POS_W+15:0] height_prod;
	vec_t height_scaled;

	////////////////////////////////////////
	// combinational math

	always_comb begin
		// target minus light, both unsigned so zero-extend first
		dx = $signed({1'b0, x_com}) - $signed({1'b0, x_light});
		dy = $signed({1'b0, y_com}) - $signed({1'b0, y_light});

		// vectoring only converges for x >= 0
		// so flip left-half vectors through the origin
		// and start the accumulated angle at a half turn
		if (dx < 0) begin
			fold_x = -vec_t'(dx);
			fold_y = -vec_t'(dy);
			fold_z = HALF_TURN;
		end else begin
			fold_x = vec_t'(dx);
			fold_y = vec_t'(dy);
			fold_z = '0;
		end

		// tilt chain compares height against distance*gain
		// so give height the same gain up front
		height_prod = height * CORDIC_GAIN;
		height_scaled = vec_t'(height_prod >> GAIN_FRAC);
	end

	////////////////////////////////////////
	// pipeline register

	// valid bit only
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		out_x   <= fold_x;
		out_y   <= fold_y;
		out_z   <= fold_z;
		out_aux <= height_scaled;
	end

endmodule

`default_nettype wire

// ==== source/cordic_stage.sv ====
/*
 * one registered CORDIC vectoring micro-rotation
 * drives y toward zero and carries a payload word alongside
 */
`timescale 1ns/1ps
`default_nettype none

module cordic_stage import pan_tilt_pkg::*; #(
	// iteration index, sets the shift and the table entry
	parameter int STAGE = 0
) (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  vec_t in_x,
	input  vec_t in_y,
	input  ang_t in_z,
	input  vec_t in_aux,
	output logic out_valid,
	output vec_t out_x,
	output vec_t out_y,
	output ang_t out_z,
	output vec_t out_aux
);

	// shifted copies, arithmetic so sign is kept
	vec_t x_shr;
	vec_t y_shr;

	// rotated values before the register
	vec_t next_x;
	vec_t next_y;
	ang_t next_z;

	////////////////////////////////////////
	// micro-rotation

	always_comb begin
		x_shr = in_x >>> STAGE;
		y_shr = in_y >>> STAGE;

		// y above the axis: rotate clockwise, angle grows
		if (!in_y[VEC_W-1]) begin
			next_x = in_x + y_shr;
			next_y = in_y - x_shr;
			next_z = in_z + ATAN_TABLE[STAGE];
		// y below the axis: rotate the other way
		end else begin
			next_x = in_x - y_shr;
			next_y = in_y + x_shr;
			next_z = in_z - ATAN_TABLE[STAGE];
		end
	end

	////////////////////////////////////////
	// pipeline register

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// data moves every cycle, qualified by out_valid
	always_ff @(posedge clk) begin
		out_x   <= next_x;
		out_y   <= next_y;
		out_z   <= next_z;
		// payload rides along untouched
		out_aux <= in_aux;
	end

endmodule

`default_nettype wire

// ==== source/angle_to_dmx.sv ====
/*
 * maps the final pan and tilt angles to DMX channel bytes
 */
`timescale 1ns/1ps
`default_nettype none

module angle_to_dmx import pan_tilt_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  ang_t in_z,
	input  vec_t in_aux,
	output logic out_valid,
	output dmx_t pan,
	output dmx_t tilt
);

	// pan angle as carried in the payload word
	ang_t pan_ang;

	// pan rotated so straight east lands on 128
	ang_t pan_offset;

	// tilt angle recovered from the accumulated z
	logic signed [ANG_W-1:0] tilt_ang;

	dmx_t pan_byte;
	dmx_t tilt_byte;

	////////////////////////////////////////
	// angle mapping

	always_comb begin
		// upper aux bits are zero fill
		pan_ang = in_aux[ANG_W-1:0];

		// wraps mod one full turn
		pan_offset = pan_ang + HALF_TURN;
		pan_byte = pan_offset[ANG_W-1:ANG_W-8];

		// tilt chain started its z at the pan angle
		tilt_ang = $signed(in_z - pan_ang);

		// shift by TILT_SHIFT then clamp to 0..255
		// a quarter turn is exactly where the shifted value hits 256
		if (tilt_ang < 0) begin
			tilt_byte = 8'd0;
		end else if (tilt_ang >= $signed({1'b0, QUARTER_TURN})) begin
			tilt_byte = 8'd255;
		end else begin
			tilt_byte = tilt_ang[TILT_SHIFT +: 8];
		end
	end

	////////////////////////////////////////
	// output registers

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// bytes hold between samples
	always_ff @(posedge clk) begin
		if (in_valid) begin
			pan  <= pan_byte;
			tilt <= tilt_byte;
		end
	end

endmodule

`default_nettype wire

// ==== source/pan_tilt_top.sv ====
/*
 * pan/tilt motion calculator top level
 * setup, pan CORDIC chain, tilt CORDIC chain, DMX byte mapper
 */
`timescale 1ns/1ps
`default_nettype none

module pan_tilt_top import pan_tilt_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  pos_t x_com,
	input  pos_t y_com,
	input  pos_t x_light,
	input  pos_t y_light,
	input  pos_t height,
	output logic out_valid,
	output dmx_t pan,
	output dmx_t tilt
);

	////////////////////////////////////////
	// pipeline nets

	// index k is the input of stage k, index N_STAGES the chain output
	logic pan_valid [0:N_STAGES];
	vec_t pan_x     [0:N_STAGES];
	vec_t pan_y     [0:N_STAGES];
	ang_t pan_z     [0:N_STAGES];
	vec_t pan_aux   [0:N_STAGES];

	// tilt x/y at the last index are residues, only z and aux go on
	logic tilt_valid [0:N_STAGES];
	vec_t tilt_x     [0:N_STAGES];
	vec_t tilt_y     [0:N_STAGES];
	ang_t tilt_z     [0:N_STAGES];
	vec_t tilt_aux   [0:N_STAGES];

	////////////////////////////////////////
	// setup, 1 cycle

	aim_setup setup (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.x_com     (x_com),
		.y_com     (y_com),
		.x_light   (x_light),
		.y_light   (y_light),
		.height    (height),
		.out_valid (pan_valid[0]),
		.out_x     (pan_x[0]),
		.out_y     (pan_y[0]),
		.out_z     (pan_z[0]),
		.out_aux   (pan_aux[0])
	);

	////////////////////////////////////////
	// pan chain, N_STAGES cycles

	// rotates (dx, dy) onto the x axis
	// z ends at the pan angle, x at distance*gain
	for (genvar i = 0; i < N_STAGES; i++) begin : g_pan
		cordic_stage #(.STAGE(i)) stage (
			.clk       (clk),
			.reset     (reset),
			.in_valid  (pan_valid[i]),
			.in_x      (pan_x[i]),
			.in_y      (pan_y[i]),
			.in_z      (pan_z[i]),
			.in_aux    (pan_aux[i]),
			.out_valid (pan_valid[i+1]),
			.out_x     (pan_x[i+1]),
			.out_y     (pan_y[i+1]),
			.out_z     (pan_z[i+1]),
			.out_aux   (pan_aux[i+1])
		);
	end

	////////////////////////////////////////
	// chain crossover

	// scaled height becomes x, distance becomes y
	// both carry the same gain so the ratio is exact
	assign tilt_valid[0] = pan_valid[N_STAGES];
	assign tilt_x[0]     = pan_aux[N_STAGES];
	assign tilt_y[0]     = pan_x[N_STAGES];

	// z keeps accumulating on top of pan
	// pan also rides as payload so the mapper can subtract it back out
	assign tilt_z[0]   = pan_z[N_STAGES];
	assign tilt_aux[0] = {{(VEC_W-ANG_W){1'b0}}, pan_z[N_STAGES]};

	////////////////////////////////////////
	// tilt chain, N_STAGES cycles

	for (genvar i = 0; i < N_STAGES; i++) begin : g_tilt
		cordic_stage #(.STAGE(i)) stage (
			.clk       (clk),
			.reset     (reset),
			.in_valid  (tilt_valid[i]),
			.in_x      (tilt_x[i]),
			.in_y      (tilt_y[i]),
			.in_z      (tilt_z[i]),
			.in_aux    (tilt_aux[i]),
			.out_valid (tilt_valid[i+1]),
			.out_x     (tilt_x[i+1]),
			.out_y     (tilt_y[i+1]),
			.out_z     (tilt_z[i+1]),
			.out_aux   (tilt_aux[i+1])
		);
	end

	////////////////////////////////////////
	// DMX byte mapping, 1 cycle

	angle_to_dmx mapper (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (tilt_valid[N_STAGES]),
		.in_z      (tilt_z[N_STAGES]),
		.in_aux    (tilt_aux[N_STAGES]),
		.out_valid (out_valid),
		.pan       (pan),
		.tilt      (tilt)
	);

endmodule

`default_nettype wire

// ==== verif/pan_tilt_model.svh ====
/*
 * reference model for the pan/tilt calculator
 * bit-exact pan and tilt bytes, plus the xorshift generator
 */
`ifndef PAN_TILT_MODEL_SVH
`define PAN_TILT_MODEL_SVH

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] r;
	r = s ^ (s << 13);
	r = r ^ (r >> 17);
	r = r ^ (r << 5);
	return r;
endfunction

// N_STAGES vectoring steps, y driven to zero
function automatic void vector_rotate(inout vec_t x, inout vec_t y, inout ang_t z);
	vec_t xs;
	vec_t ys;
	for (int i = 0; i < N_STAGES; i++) begin
		xs = x >>> i;
		ys = y >>> i;
		if (y >= 0) begin
			x = x + ys;
			y = y - xs;
			z = z + ATAN_TABLE[i];
		end else begin
			x = x - ys;
			y = y + xs;
			z = z - ATAN_TABLE[i];
		end
	end
endfunction

// returns {pan, tilt}
function automatic logic [15:0] pan_tilt_ref(input pos_t xc, input pos_t yc,
		input pos_t xl, input pos_t yl, input pos_t h);
	int dx;
	int dy;
	int t;
	vec_t px;
	vec_t py;
	vec_t tx;
	vec_t ty;
	ang_t pz;
	ang_t tz;
	ang_t pan_ofs;
	logic [7:0] tilt_b;
	dx = int'(xc) - int'(xl);
	dy = int'(yc) - int'(yl);
	pz = '0;
	// left half-plane: mirror through origin, start half a turn round
	if (dx < 0) begin
		dx = -dx;
		dy = -dy;
		pz = HALF_TURN;
	end
	px = vec_t'(dx);
	py = vec_t'(dy);
	vector_rotate(px, py, pz);

	// tilt x is gain-scaled height, tilt y is distance with gain
	tx = vec_t'((int'(h) * int'(CORDIC_GAIN)) >>> GAIN_FRAC);
	ty = px;
	tz = pz;
	vector_rotate(tx, ty, tz);

	pan_ofs = pz + HALF_TURN;
	t = int'($signed(ang_t'(tz - pz))) >>> TILT_SHIFT;
	if (t < 0)
		tilt_b = 8'd0;
	else if (t > 255)
		tilt_b = 8'd255;
	else
		tilt_b = t[7:0];
	return {pan_ofs[ANG_W-1:ANG_W-8], tilt_b};
endfunction

`endif

// ==== verif/tb_pan_tilt.sv ====
/*
 * testbench for the pan/tilt motion calculator
 */
`timescale 1ns/1ps
`default_nettype none

module tb_pan_tilt import pan_tilt_pkg::*; ();

	`include "pan_tilt_model.svh"

	localparam int RESET_CYCLES = 8;
	localparam int N_STREAM = 300;
	localparam int N_SPARSE = 20;
	localparam int MAX_GAP = 12;
	// longer than the pipe, so results are already coming out when reset hits
	localparam int N_BURST = LATENCY + 10;
	// all samples, worst-case gaps, two resets, one drain per test
	localparam int MAX_CYCLES = 2 * RESET_CYCLES + 6 + N_STREAM
		+ N_SPARSE * (MAX_GAP + 1) + 2 * N_BURST + 8 * LATENCY + 100;

	logic clk;
	logic reset;
	logic in_valid;
	pos_t x_com;
	pos_t y_com;
	pos_t x_light;
	pos_t y_light;
	pos_t height;
	logic out_valid;
	dmx_t pan;
	dmx_t tilt;

	// expected results and the cycle each sample went in
	int exp_pan [$];
	int exp_tilt [$];
	int exp_cycle [$];

	int cycle = 0;
	logic [31:0] rng_state = 32'h60f3;
	logic reset_seen = 1'b0;

	pan_tilt_top UUT (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.x_com     (x_com),
		.y_com     (y_com),
		.x_light   (x_light),
		.y_light   (y_light),
		.height    (height),
		.out_valid (out_valid),
		.pan       (pan),
		.tilt      (tilt)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////
	// helpers

	task automatic fail_run(input string reason);
		$display("%s at %0t", reason, $time);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// drive one sample for a cycle, queue what should come out
	task automatic send_sample(input pos_t xc, input pos_t yc, input pos_t xl,
			input pos_t yl, input pos_t h);
		logic [15:0] expected;
		expected = pan_tilt_ref(xc, yc, xl, yl, h);
		x_com = xc;
		y_com = yc;
		x_light = xl;
		y_light = yl;
		height = h;
		in_valid = 1'b1;
		exp_pan.push_back(int'(expected[15:8]));
		exp_tilt.push_back(int'(expected[7:0]));
		exp_cycle.push_back(cycle);
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic send_random();
		pos_t v [5];
		for (int k = 0; k < 5; k++) begin
			rng_state = xorshift32(rng_state);
			v[k] = rng_state[POS_W-1:0];
		end
		send_sample(v[0], v[1], v[2], v[3], v[4]);
	endtask

	// the cycle counter bounds this
	task automatic wait_drain();
		while (exp_pan.size() != 0)
			@(posedge clk);
		#1;
	endtask

	////////////////////////////////////////
	// cycle counter and timeout

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES)
			fail_run("timeout: expected outputs never arrived");
	end

	////////////////////////////////////////
	// compare, sampled mid-cycle

	always @(negedge clk) begin
		if (reset) begin
			// first reset cycle may still show an old result
			if (out_valid && reset_seen)
				fail_run("out_valid went high while reset was held");
			reset_seen = 1'b1;
			exp_pan.delete();
			exp_tilt.delete();
			exp_cycle.delete();
		end else begin
			reset_seen = 1'b0;
			if (out_valid) begin
				if (exp_pan.size() == 0) begin
					fail_run("out_valid with no sample in flight");
				end else begin
					check_value("latency", cycle - exp_cycle.pop_front(), LATENCY);
					check_value("pan", int'(pan), exp_pan.pop_front());
					check_value("tilt", int'(tilt), exp_tilt.pop_front());
				end
			end
		end
	end

	////////////////////////////////////////
	// stimulus

	initial begin
		logic [15:0] model_out;
		int gap;
		reset = 1'b1;
		in_valid = 1'b0;
		x_com = '0;
		y_com = '0;
		x_light = '0;
		y_light = '0;
		height = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		// compass points around a light at (2000, 2000)
		send_sample(12'd2500, 12'd2000, 12'd2000, 12'd2000, 12'd1000);
		send_sample(12'd2000, 12'd2500, 12'd2000, 12'd2000, 12'd1000);
		send_sample(12'd1500, 12'd2000, 12'd2000, 12'd2000, 12'd1000);
		send_sample(12'd2000, 12'd1500, 12'd2000, 12'd2000, 12'd1000);
		wait_drain();

		// straight down, then zero height far away
		model_out = pan_tilt_ref(12'd1000, 12'd1000, 12'd1000, 12'd1000, 12'd800);
		check_value("model tilt below light", int'(model_out[7:0]), 0);
		model_out = pan_tilt_ref(12'd3500, 12'd300, 12'd200, 12'd3000, 12'd0);
		check_value("model tilt at horizon", int'(model_out[7:0]), 255);
		send_sample(12'd1000, 12'd1000, 12'd1000, 12'd1000, 12'd800);
		send_sample(12'd3500, 12'd300, 12'd200, 12'd3000, 12'd0);
		wait_drain();

		// back to back
		for (int n = 0; n < N_STREAM; n++)
			send_random();
		wait_drain();

		// sparse, random idle gaps
		for (int n = 0; n < N_SPARSE; n++) begin
			send_random();
			rng_state = xorshift32(rng_state);
			gap = int'(rng_state[7:0]) % MAX_GAP + 1;
			repeat (gap) @(posedge clk);
			#1;
		end
		wait_drain();

		// reset with the pipeline full
		for (int n = 0; n < N_BURST; n++)
			send_random();
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		// nothing may come out of an empty pipe
		repeat (LATENCY + 5) @(posedge clk);
		#1;
		for (int n = 0; n < N_BURST; n++)
			send_random();
		wait_drain();

		if (exp_pan.size() == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			fail_run("results still missing at end of run");
		end
	end

endmodule

`default_nettype wire

// ==== pan_tilt.f ====
+incdir+verif
source/pan_tilt_pkg.sv
source/aim_setup.sv
source/cordic_stage.sv
source/angle_to_dmx.sv
source/pan_tilt_top.sv
verif/tb_pan_tilt.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_pan_tilt -f pan_tilt.f

output=$(./obj_dir/Vtb_pan_tilt 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
